//--- include/delay_calc_defs.svh
// Sizes, field widths and rank costs of the DRAM delay calculator.
// Included by the package and by every module that needs one of them.
`ifndef DELAY_CALC_DEFS_SVH
`define DELAY_CALC_DEFS_SVH

// Slot tables
`define NUM_W_SLOTS 4
`define NUM_R_SLOTS 4
`define MAX_BURST_LEN 4
`define AGE_WIDTH 3

// Address request fields
// A burst length holds 1 to 4
`define LEN_WIDTH 3
`define SIZE_WIDTH 3
`define ADDR_WIDTH 16
`define COL_WIDTH 10
`define IID_WIDTH 3

// Release bits per response bank
`define BANK_CAPACITY 8

// Rank costs in cycles
`define CAS_COST 4
`define ACT_COST 3
`define PRE_COST 3

// Wide enough for the sum of all three costs
`define DELAY_WIDTH 4

`endif

//--- hw/delay_calc_pkg.sv
// Types shared by the slot tables and the rank scheduler.
// A memory address is read either as one word, for burst beat arithmetic,
// or as a row and a column, for the row-buffer cost model.
`include "delay_calc_defs.svh"

package delay_calc_pkg;

  typedef union packed {
    logic [`ADDR_WIDTH-1:0] full;
    struct packed {
      // Row selects the DRAM page, col is the offset inside it
      logic [`ADDR_WIDTH-`COL_WIDTH-1:0] row;
      logic [`COL_WIDTH-1:0]             col;
    } row_col;
  } mem_addr_u;

endpackage

//--- hw/write_slot_table.sv
// Write burst slot table.
// Accepts write addresses into free slots and write data beats into the
// oldest burst still missing data. Offers one servable beat to the rank
// scheduler and reports each burst once all its beats are done.
`include "delay_calc_defs.svh"

module write_slot_table import delay_calc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    i_waddr_valid,
  input  logic [`IID_WIDTH-1:0]   i_waddr_iid,
  input  logic [`ADDR_WIDTH-1:0]  i_waddr_addr,
  input  logic [`SIZE_WIDTH-1:0]  i_waddr_size,
  input  logic [`LEN_WIDTH-1:0]   i_waddr_len,
  output logic                    o_waddr_ready,
  input  logic                    i_wdata_valid,
  output logic                    o_wdata_ready,
  output logic                    o_cand_valid,
  output mem_addr_u               o_cand_addr,
  input  logic                    i_grant,
  input  logic                    i_done,
  output logic                    o_complete,
  output logic [`IID_WIDTH-1:0]   o_complete_iid
);

  localparam int slot_w = $clog2(`NUM_W_SLOTS);
  localparam int beat_w = $clog2(`MAX_BURST_LEN);

  logic [`NUM_W_SLOTS-1:0]   slot_v_q, slot_v_d;
  logic [`AGE_WIDTH-1:0]     age_q [`NUM_W_SLOTS];
  logic [`AGE_WIDTH-1:0]     age_d [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] data_q [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] data_d [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] pend_q [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] pend_d [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] done_q [`NUM_W_SLOTS];
  logic [`MAX_BURST_LEN-1:0] done_d [`NUM_W_SLOTS];

  // Burst payload, written on acceptance only
  logic [`IID_WIDTH-1:0]  iid_q  [`NUM_W_SLOTS];
  mem_addr_u              base_q [`NUM_W_SLOTS];
  logic [`SIZE_WIDTH-1:0] size_q [`NUM_W_SLOTS];

  logic [slot_w-1:0] alloc_slot, data_slot, cand_slot, cmp_slot;
  logic [beat_w-1:0] data_beat, cand_beat;
  logic              waddr_fire, wdata_fire;

  assign waddr_fire = i_waddr_valid && o_waddr_ready;
  assign wdata_fire = i_wdata_valid && o_wdata_ready;

  // Slot searches, all from registered state
  always_comb begin
    logic [`MAX_BURST_LEN-1:0] servable;
    logic [`AGE_WIDTH-1:0]     data_age, cand_age;
    o_waddr_ready  = 1'b0;
    o_wdata_ready  = 1'b0;
    o_cand_valid   = 1'b0;
    o_complete     = 1'b0;
    alloc_slot     = '0;
    data_slot      = '0;
    cand_slot      = '0;
    cmp_slot       = '0;
    data_age       = '0;
    cand_age       = '0;
    for (int s = `NUM_W_SLOTS - 1; s >= 0; s--) begin
      if (!slot_v_q[s]) begin
        o_waddr_ready = 1'b1;
        alloc_slot    = slot_w'(s);
      end
      if (slot_v_q[s] && &done_q[s]) begin
        o_complete = 1'b1;
        cmp_slot   = slot_w'(s);
      end
    end
    // Oldest slot wins, ties go to the lower index
    for (int s = 0; s < `NUM_W_SLOTS; s++) begin
      servable = data_q[s] & ~pend_q[s] & ~done_q[s];
      if (slot_v_q[s] && !(&data_q[s]) && (!o_wdata_ready || age_q[s] > data_age)) begin
        o_wdata_ready = 1'b1;
        data_slot     = slot_w'(s);
        data_age      = age_q[s];
      end
      if (slot_v_q[s] && |servable && (!o_cand_valid || age_q[s] > cand_age)) begin
        o_cand_valid = 1'b1;
        cand_slot    = slot_w'(s);
        cand_age     = age_q[s];
      end
    end
    // Lowest missing data beat and lowest servable beat of the chosen slots
    data_beat = '0;
    cand_beat = '0;
    servable  = data_q[cand_slot] & ~pend_q[cand_slot] & ~done_q[cand_slot];
    for (int b = `MAX_BURST_LEN - 1; b >= 0; b--) begin
      if (!data_q[data_slot][b]) data_beat = beat_w'(b);
      if (servable[b]) cand_beat = beat_w'(b);
    end
  end

  assign o_cand_addr.full = base_q[cand_slot].full +
                            (`ADDR_WIDTH'(cand_beat) << size_q[cand_slot]);
  assign o_complete_iid   = iid_q[cmp_slot];

  always_comb begin
    slot_v_d = slot_v_q;
    age_d    = age_q;
    data_d   = data_q;
    pend_d   = pend_q;
    done_d   = done_q;
    if (o_complete) slot_v_d[cmp_slot] = 1'b0;
    // A finished rank beat turns the pending beat into done
    if (i_done) begin
      for (int s = 0; s < `NUM_W_SLOTS; s++) begin
        done_d[s] = done_q[s] | pend_q[s];
        pend_d[s] = '0;
      end
    end
    if (i_grant && o_cand_valid) pend_d[cand_slot][cand_beat] = 1'b1;
    if (wdata_fire) data_d[data_slot][data_beat] = 1'b1;
    if (waddr_fire) begin
      for (int s = 0; s < `NUM_W_SLOTS; s++) begin
        if (slot_v_q[s] && age_q[s] != '1) age_d[s] = age_q[s] + 1'b1;
      end
      slot_v_d[alloc_slot] = 1'b1;
      age_d[alloc_slot]    = '0;
      pend_d[alloc_slot]   = '0;
      // Beats past the burst length count as done and already written
      for (int b = 0; b < `MAX_BURST_LEN; b++) begin
        data_d[alloc_slot][b] = (b >= i_waddr_len);
        done_d[alloc_slot][b] = (b >= i_waddr_len);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q <= '0;
      age_q    <= '{default: '0};
      data_q   <= '{default: '0};
      pend_q   <= '{default: '0};
      done_q   <= '{default: '0};
    end else begin
      slot_v_q <= slot_v_d;
      age_q    <= age_d;
      data_q   <= data_d;
      pend_q   <= pend_d;
      done_q   <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (waddr_fire) begin
      iid_q[alloc_slot]       <= i_waddr_iid;
      base_q[alloc_slot].full <= i_waddr_addr;
      size_q[alloc_slot]      <= i_waddr_size;
    end
  end

endmodule

//--- hw/read_slot_table.sv
// Read burst slot table.
// Accepts read addresses into free slots, offers the lowest open beat of
// the oldest burst to the rank scheduler and reports finished bursts.
`include "delay_calc_defs.svh"

module read_slot_table import delay_calc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    i_raddr_valid,
  input  logic [`IID_WIDTH-1:0]   i_raddr_iid,
  input  logic [`ADDR_WIDTH-1:0]  i_raddr_addr,
  input  logic [`SIZE_WIDTH-1:0]  i_raddr_size,
  input  logic [`LEN_WIDTH-1:0]   i_raddr_len,
  output logic                    o_raddr_ready,
  output logic                    o_cand_valid,
  output mem_addr_u               o_cand_addr,
  input  logic                    i_grant,
  input  logic                    i_done,
  output logic                    o_complete,
  output logic [`IID_WIDTH-1:0]   o_complete_iid
);

  localparam int slot_w = $clog2(`NUM_R_SLOTS);
  localparam int beat_w = $clog2(`MAX_BURST_LEN);

  logic [`NUM_R_SLOTS-1:0]   slot_v_q, slot_v_d;
  logic [`AGE_WIDTH-1:0]     age_q [`NUM_R_SLOTS];
  logic [`AGE_WIDTH-1:0]     age_d [`NUM_R_SLOTS];
  logic [`MAX_BURST_LEN-1:0] pend_q [`NUM_R_SLOTS];
  logic [`MAX_BURST_LEN-1:0] pend_d [`NUM_R_SLOTS];
  logic [`MAX_BURST_LEN-1:0] done_q [`NUM_R_SLOTS];
  logic [`MAX_BURST_LEN-1:0] done_d [`NUM_R_SLOTS];

  logic [`IID_WIDTH-1:0]  iid_q  [`NUM_R_SLOTS];
  mem_addr_u              base_q [`NUM_R_SLOTS];
  logic [`SIZE_WIDTH-1:0] size_q [`NUM_R_SLOTS];

  logic [slot_w-1:0] alloc_slot, cand_slot, cmp_slot;
  logic [beat_w-1:0] cand_beat;
  logic              raddr_fire;

  assign raddr_fire = i_raddr_valid && o_raddr_ready;

  always_comb begin
    logic [`AGE_WIDTH-1:0] cand_age;
    o_raddr_ready = 1'b0;
    o_cand_valid  = 1'b0;
    o_complete    = 1'b0;
    alloc_slot    = '0;
    cand_slot     = '0;
    cmp_slot      = '0;
    cand_age      = '0;
    cand_beat     = '0;
    for (int s = `NUM_R_SLOTS - 1; s >= 0; s--) begin
      if (!slot_v_q[s]) begin
        o_raddr_ready = 1'b1;
        alloc_slot    = slot_w'(s);
      end
      if (slot_v_q[s] && &done_q[s]) begin
        o_complete = 1'b1;
        cmp_slot   = slot_w'(s);
      end
    end
    // Every real beat is servable as soon as the address is in
    for (int s = 0; s < `NUM_R_SLOTS; s++) begin
      if (slot_v_q[s] && !(&(pend_q[s] | done_q[s])) &&
          (!o_cand_valid || age_q[s] > cand_age)) begin
        o_cand_valid = 1'b1;
        cand_slot    = slot_w'(s);
        cand_age     = age_q[s];
      end
    end
    for (int b = `MAX_BURST_LEN - 1; b >= 0; b--) begin
      if (!pend_q[cand_slot][b] && !done_q[cand_slot][b]) cand_beat = beat_w'(b);
    end
  end

  assign o_cand_addr.full = base_q[cand_slot].full +
                            (`ADDR_WIDTH'(cand_beat) << size_q[cand_slot]);
  assign o_complete_iid   = iid_q[cmp_slot];

  always_comb begin
    slot_v_d = slot_v_q;
    age_d    = age_q;
    pend_d   = pend_q;
    done_d   = done_q;
    if (o_complete) slot_v_d[cmp_slot] = 1'b0;
    if (i_done) begin
      for (int s = 0; s < `NUM_R_SLOTS; s++) begin
        done_d[s] = done_q[s] | pend_q[s];
        pend_d[s] = '0;
      end
    end
    if (i_grant && o_cand_valid) pend_d[cand_slot][cand_beat] = 1'b1;
    if (raddr_fire) begin
      // Ages saturate so the oldest burst stays on top
      for (int s = 0; s < `NUM_R_SLOTS; s++) begin
        if (slot_v_q[s] && age_q[s] != '1) age_d[s] = age_q[s] + 1'b1;
      end
      slot_v_d[alloc_slot] = 1'b1;
      age_d[alloc_slot]    = '0;
      pend_d[alloc_slot]   = '0;
      for (int b = 0; b < `MAX_BURST_LEN; b++) begin
        done_d[alloc_slot][b] = (b >= i_raddr_len);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q <= '0;
      age_q    <= '{default: '0};
      pend_q   <= '{default: '0};
      done_q   <= '{default: '0};
    end else begin
      slot_v_q <= slot_v_d;
      age_q    <= age_d;
      pend_q   <= pend_d;
      done_q   <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (raddr_fire) begin
      iid_q[alloc_slot]       <= i_raddr_iid;
      base_q[alloc_slot].full <= i_raddr_addr;
      size_q[alloc_slot]      <= i_raddr_size;
    end
  end

endmodule

//--- hw/rank_scheduler.sv
// Single-rank scheduler with a row-buffer cost model.
// Grants one beat at a time, write side first, loads the beat cost into
// the delay counter and pulses done for the side in flight when the
// counter runs out. A new grant may start on that same edge.
`include "delay_calc_defs.svh"

module rank_scheduler import delay_calc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      i_w_cand_valid,
  input  mem_addr_u i_w_cand_addr,
  input  logic      i_r_cand_valid,
  input  mem_addr_u i_r_cand_addr,
  output logic      o_w_grant,
  output logic      o_r_grant,
  output logic      o_w_done,
  output logic      o_r_done
);

  localparam int row_w   = `ADDR_WIDTH - `COL_WIDTH;
  localparam int delay_w = `DELAY_WIDTH;

  // Column access only on a hit, activation on a closed bank,
  // precharge on top for a different row
  function automatic logic [delay_w-1:0] beat_cost(mem_addr_u addr, logic is_open,
                                                   logic [row_w-1:0] open_row);
    if (is_open && addr.row_col.row == open_row) begin
      return delay_w'(`CAS_COST);
    end else if (!is_open) begin
      return delay_w'(`CAS_COST + `ACT_COST);
    end else begin
      return delay_w'(`CAS_COST + `ACT_COST + `PRE_COST);
    end
  endfunction

  logic               row_open_q;
  logic [row_w-1:0]   open_row_q;
  logic [delay_w-1:0] cnt_q;
  logic               inflight_w_q;

  logic               rank_free;
  logic               last_cycle;
  logic               grant;
  mem_addr_u          grant_addr;
  logic [delay_w-1:0] grant_cost;

  // Count of 1 means the beat in flight ends on the coming edge
  assign last_cycle = (cnt_q == delay_w'(1));
  assign rank_free  = (cnt_q == '0) || last_cycle;

  assign o_w_grant = rank_free && i_w_cand_valid;
  assign o_r_grant = rank_free && !i_w_cand_valid && i_r_cand_valid;
  assign grant     = o_w_grant || o_r_grant;

  assign o_w_done = last_cycle && inflight_w_q;
  assign o_r_done = last_cycle && !inflight_w_q;

  assign grant_addr = i_w_cand_valid ? i_w_cand_addr : i_r_cand_addr;
  assign grant_cost = beat_cost(grant_addr, row_open_q, open_row_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_open_q   <= 1'b0;
      cnt_q        <= '0;
      inflight_w_q <= 1'b0;
    end else if (grant) begin
      row_open_q   <= 1'b1;
      cnt_q        <= grant_cost;
      inflight_w_q <= o_w_grant;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Row of the most recently granted beat
  always_ff @(posedge clk_i) begin
    if (grant) begin
      open_row_q <= grant_addr.row_col.row;
    end
  end

endmodule

//--- hw/release_register.sv
// Release enable bits of one response bank, one bit per internal id.
// A burst completion sets its bit, the bank's one-hot feedback clears it.
`include "delay_calc_defs.svh"

module release_register #(
  parameter int CAPACITY = `BANK_CAPACITY
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        i_set_valid,
  input  logic [$clog2(CAPACITY)-1:0] i_set_iid,
  input  logic [CAPACITY-1:0]         i_released_onehot,
  output logic [CAPACITY-1:0]         o_release_en
);

  logic [CAPACITY-1:0] set_mask;
  logic [CAPACITY-1:0] en_q;

  always_comb begin
    set_mask = '0;
    if (i_set_valid) set_mask[i_set_iid] = 1'b1;
  end

  // Set is applied last so it wins over a clear of the same bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q <= '0;
    end else begin
      en_q <= (en_q & ~i_released_onehot) | set_mask;
    end
  end

  assign o_release_en = en_q;

endmodule

//--- hw/delay_calc_top.sv
// Top level of the DRAM rank delay calculator.
// Write and read slot tables feed one rank scheduler, and completed
// bursts raise release bits in the write response and read data banks.
`include "delay_calc_defs.svh"

module delay_calc_top import delay_calc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      i_waddr_valid,
  input  logic [`IID_WIDTH-1:0]     i_waddr_iid,
  input  logic [`ADDR_WIDTH-1:0]    i_waddr_addr,
  input  logic [`SIZE_WIDTH-1:0]    i_waddr_size,
  input  logic [`LEN_WIDTH-1:0]     i_waddr_len,
  output logic                      o_waddr_ready,
  input  logic                      i_wdata_valid,
  output logic                      o_wdata_ready,
  input  logic                      i_raddr_valid,
  input  logic [`IID_WIDTH-1:0]     i_raddr_iid,
  input  logic [`ADDR_WIDTH-1:0]    i_raddr_addr,
  input  logic [`SIZE_WIDTH-1:0]    i_raddr_size,
  input  logic [`LEN_WIDTH-1:0]     i_raddr_len,
  output logic                      o_raddr_ready,
  output logic [`BANK_CAPACITY-1:0] o_wresp_release_en,
  output logic [`BANK_CAPACITY-1:0] o_rdata_release_en,
  input  logic [`BANK_CAPACITY-1:0] i_wresp_released,
  input  logic [`BANK_CAPACITY-1:0] i_rdata_released
);

  logic                  w_cand_valid, r_cand_valid;
  mem_addr_u             w_cand_addr, r_cand_addr;
  logic                  w_grant, r_grant;
  logic                  w_done, r_done;
  logic                  w_complete, r_complete;
  logic [`IID_WIDTH-1:0] w_complete_iid, r_complete_iid;

  write_slot_table u_wr_table (
    .clk_i, .rst_ni,
    .i_waddr_valid, .i_waddr_iid, .i_waddr_addr, .i_waddr_size, .i_waddr_len,
    .o_waddr_ready,
    .i_wdata_valid, .o_wdata_ready,
    .o_cand_valid   (w_cand_valid),
    .o_cand_addr    (w_cand_addr),
    .i_grant        (w_grant),
    .i_done         (w_done),
    .o_complete     (w_complete),
    .o_complete_iid (w_complete_iid)
  );

  read_slot_table u_rd_table (
    .clk_i, .rst_ni,
    .i_raddr_valid, .i_raddr_iid, .i_raddr_addr, .i_raddr_size, .i_raddr_len,
    .o_raddr_ready,
    .o_cand_valid   (r_cand_valid),
    .o_cand_addr    (r_cand_addr),
    .i_grant        (r_grant),
    .i_done         (r_done),
    .o_complete     (r_complete),
    .o_complete_iid (r_complete_iid)
  );

  rank_scheduler u_rank (
    .clk_i, .rst_ni,
    .i_w_cand_valid (w_cand_valid),
    .i_w_cand_addr  (w_cand_addr),
    .i_r_cand_valid (r_cand_valid),
    .i_r_cand_addr  (r_cand_addr),
    .o_w_grant      (w_grant),
    .o_r_grant      (r_grant),
    .o_w_done       (w_done),
    .o_r_done       (r_done)
  );

  // Write response bank
  release_register #(.CAPACITY(`BANK_CAPACITY)) u_wresp_release (
    .clk_i, .rst_ni,
    .i_set_valid       (w_complete),
    .i_set_iid         (w_complete_iid),
    .i_released_onehot (i_wresp_released),
    .o_release_en      (o_wresp_release_en)
  );

  // Read data bank
  release_register #(.CAPACITY(`BANK_CAPACITY)) u_rdata_release (
    .clk_i, .rst_ni,
    .i_set_valid       (r_complete),
    .i_set_iid         (r_complete_iid),
    .i_released_onehot (i_rdata_released),
    .o_release_en      (o_rdata_release_en)
  );

endmodule

//--- testbench/delay_calc_tb.sv
// Testbench for the DRAM rank delay calculator.
// Drives reset, read latency, row miss, write data, back-pressure and
// write priority scenarios into delay_calc_top on the falling clock edge.
// Assertions do the checking, and one closing line gives the error counts.
`include "delay_calc_defs.svh"

module delay_calc_tb import delay_calc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int row_w      = `ADDR_WIDTH - `COL_WIDTH;
  localparam int max_cycles = 3000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      i_waddr_valid;
  logic [`IID_WIDTH-1:0]     i_waddr_iid;
  logic [`ADDR_WIDTH-1:0]    i_waddr_addr;
  logic [`SIZE_WIDTH-1:0]    i_waddr_size;
  logic [`LEN_WIDTH-1:0]     i_waddr_len;
  logic                      o_waddr_ready;
  logic                      i_wdata_valid;
  logic                      o_wdata_ready;
  logic                      i_raddr_valid;
  logic [`IID_WIDTH-1:0]     i_raddr_iid;
  logic [`ADDR_WIDTH-1:0]    i_raddr_addr;
  logic [`SIZE_WIDTH-1:0]    i_raddr_size;
  logic [`LEN_WIDTH-1:0]     i_raddr_len;
  logic                      o_raddr_ready;
  logic [`BANK_CAPACITY-1:0] o_wresp_release_en;
  logic [`BANK_CAPACITY-1:0] o_rdata_release_en;
  logic [`BANK_CAPACITY-1:0] i_wresp_released;
  logic [`BANK_CAPACITY-1:0] i_rdata_released;

  int unsigned value_errs;
  int unsigned other_errs;
  int unsigned cycles;
  // Data beats still owed by the write burst under test
  int unsigned data_owed;

  delay_calc_top dut0 (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // The rank serves one side per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(dut0.w_grant && dut0.r_grant))
    else begin
      other_errs++;
      $display("Both slot tables were granted in the same cycle");
    end

  // No write release while the burst under test still lacks data
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (data_owed != 0) |-> (o_wresp_release_en == '0))
    else begin
      value_errs++;
      $display("Fail o_wresp_release_en expected 0x0 got 0x%0h", o_wresp_release_en);
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == max_cycles) begin
      other_errs++;
      $display("Timeout after %0d cycles, a ready or a release bit never came", cycles);
      $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("Fail %s expected 0x%0h got 0x%0h", name, exp, act);
    end
  endtask

  // Holds an address on one channel until it is taken, returns on the next falling edge
  task automatic send_addr(input logic is_write, input logic [`IID_WIDTH-1:0] iid,
                           input logic [`ADDR_WIDTH-1:0] addr,
                           input logic [`SIZE_WIDTH-1:0] size,
                           input logic [`LEN_WIDTH-1:0] len);
    if (is_write) begin
      i_waddr_valid = 1'b1;
      i_waddr_iid   = iid;
      i_waddr_addr  = addr;
      i_waddr_size  = size;
      i_waddr_len   = len;
    end else begin
      i_raddr_valid = 1'b1;
      i_raddr_iid   = iid;
      i_raddr_addr  = addr;
      i_raddr_size  = size;
      i_raddr_len   = len;
    end
    while (!(is_write ? o_waddr_ready : o_raddr_ready)) @(negedge clk_i);
    @(posedge clk_i);
    @(negedge clk_i);
    i_waddr_valid = 1'b0;
    i_raddr_valid = 1'b0;
  endtask

  task automatic send_wdata();
    i_wdata_valid = 1'b1;
    while (!o_wdata_ready) @(negedge clk_i);
    @(posedge clk_i);
    @(negedge clk_i);
    i_wdata_valid = 1'b0;
  endtask

  // Counts rising edges until the release bit of iid is seen high
  task automatic count_to_release(input logic is_write, input logic [`IID_WIDTH-1:0] iid,
                                  output int unsigned edges);
    edges = 0;
    while (!(is_write ? o_wresp_release_en[iid] : o_rdata_release_en[iid])) begin
      @(negedge clk_i);
      edges++;
    end
  endtask

  task automatic free_bit(input logic is_write, input logic [`IID_WIDTH-1:0] iid);
    if (is_write) begin
      i_wresp_released = `BANK_CAPACITY'(1) << iid;
    end else begin
      i_rdata_released = `BANK_CAPACITY'(1) << iid;
    end
    @(negedge clk_i);
    i_wresp_released = '0;
    i_rdata_released = '0;
    if (is_write) begin
      check_val($sformatf("o_wresp_release_en[%0d]", iid), 0, o_wresp_release_en[iid]);
    end else begin
      check_val($sformatf("o_rdata_release_en[%0d]", iid), 0, o_rdata_release_en[iid]);
    end
  endtask

  // One read burst inside a single row on an idle rank
  task automatic timed_read(input logic [`IID_WIDTH-1:0] iid, input logic [row_w-1:0] row,
                            input int unsigned open_cost);
    mem_addr_u              addr;
    logic [`LEN_WIDTH-1:0]  len;
    logic [`SIZE_WIDTH-1:0] size;
    int unsigned            edges;
    len  = `LEN_WIDTH'($urandom_range(`MAX_BURST_LEN, 1));
    size = `SIZE_WIDTH'($urandom_range(3, 0));
    addr.row_col.row = row;
    // Column on a 64 byte boundary so the whole burst stays in the row
    addr.row_col.col = `COL_WIDTH'($urandom) & 10'h3c0;
    send_addr(1'b0, iid, addr.full, size, len);
    count_to_release(1'b0, iid, edges);
    check_val("o_rdata_release_en latency", 2 + open_cost + int'(len) * `CAS_COST, edges);
    free_bit(1'b0, iid);
  endtask

  task automatic write_with_data(input logic [`IID_WIDTH-1:0] iid);
    mem_addr_u             addr;
    logic [`LEN_WIDTH-1:0] len;
    int unsigned           edges;
    int unsigned           bound;
    len       = `LEN_WIDTH'($urandom_range(`MAX_BURST_LEN, 1));
    addr.full = `ADDR_WIDTH'($urandom);
    // Worst case every beat pays precharge, activation and column access
    bound     = 2 + int'(len) * (`PRE_COST + `ACT_COST + `CAS_COST);
    send_addr(1'b1, iid, addr.full, 3'd2, len);
    check_val("o_wdata_ready", 1, o_wdata_ready);
    data_owed = len;
    while (data_owed != 0) begin
      // Last beat held back longer than the whole burst could take
      if (data_owed == 1) begin
        repeat (bound) @(negedge clk_i);
      end else begin
        repeat ($urandom_range(2, 0)) @(negedge clk_i);
      end
      send_wdata();
      data_owed--;
    end
    check_val("o_wdata_ready", 0, o_wdata_ready);
    count_to_release(1'b1, iid, edges);
    assert (edges <= bound) else begin
      other_errs++;
      $display("Write release came %0d cycles after the last data beat, limit %0d",
               edges, bound);
    end
    free_bit(1'b1, iid);
  endtask

  task automatic back_pressure_test();
    int unsigned taken;
    taken        = 0;
    i_waddr_size = 3'd2;
    i_waddr_len  = 3'd1;
    for (int i = 0; i < 5; i++) begin
      i_waddr_valid = 1'b1;
      i_waddr_iid   = `IID_WIDTH'(i);
      i_waddr_addr  = `ADDR_WIDTH'($urandom);
      if (!o_waddr_ready) break;
      @(posedge clk_i);
      taken++;
      @(negedge clk_i);
    end
    check_val("accepted write addresses", `NUM_W_SLOTS, taken);
    // Without data nothing drains, so the fifth address has to wait
    repeat (4) begin
      check_val("o_waddr_ready", 0, o_waddr_ready);
      check_val("o_wresp_release_en", 0, o_wresp_release_en);
      @(negedge clk_i);
    end
    i_wdata_valid = 1'b1;
    while (!o_waddr_ready) @(negedge clk_i);
    check_val("o_wresp_release_en[0]", 1, o_wresp_release_en[0]);
    @(posedge clk_i);
    @(negedge clk_i);
    i_waddr_valid = 1'b0;
    while (o_wdata_ready) @(negedge clk_i);
    i_wdata_valid = 1'b0;
    while (o_wresp_release_en[4:0] != 5'h1f) @(negedge clk_i);
    for (int i = 0; i < 5; i++) free_bit(1'b1, `IID_WIDTH'(i));
  endtask

  task automatic write_priority_test();
    mem_addr_u             busy_addr;
    mem_addr_u             rd_addr;
    mem_addr_u             wr_addr;
    logic [`LEN_WIDTH-1:0] wr_len;
    busy_addr.full = `ADDR_WIDTH'($urandom);
    rd_addr.full   = `ADDR_WIDTH'($urandom);
    wr_addr.full   = `ADDR_WIDTH'($urandom);
    wr_len         = `LEN_WIDTH'($urandom_range(`MAX_BURST_LEN, 1));
    // Two beat read keeps the rank busy while the other bursts arrive
    send_addr(1'b0, 3'd5, busy_addr.full, 3'd0, 3'd2);
    send_addr(1'b0, 3'd6, rd_addr.full, 3'd0, `LEN_WIDTH'($urandom_range(4, 1)));
    send_addr(1'b1, 3'd6, wr_addr.full, 3'd0, wr_len);
    repeat (wr_len) send_wdata();
    check_val("o_rdata_release_en[6]", 0, o_rdata_release_en[6]);
    check_val("o_wresp_release_en[6]", 0, o_wresp_release_en[6]);
    while (!o_rdata_release_en[6]) @(negedge clk_i);
    check_val("o_wresp_release_en[6]", 1, o_wresp_release_en[6]);
    while (!o_rdata_release_en[5]) @(negedge clk_i);
    free_bit(1'b0, 3'd5);
    free_bit(1'b0, 3'd6);
    free_bit(1'b1, 3'd6);
  endtask

  initial begin
    int unsigned      seed;
    logic [row_w-1:0] first_row;
    value_errs       = 0;
    other_errs       = 0;
    cycles           = 0;
    data_owed        = 0;
    seed             = $urandom(32'ha089a5fc);
    rst_ni           = 1'b0;
    i_waddr_valid    = 1'b0;
    i_waddr_iid      = '0;
    i_waddr_addr     = '0;
    i_waddr_size     = '0;
    i_waddr_len      = '0;
    i_wdata_valid    = 1'b0;
    i_raddr_valid    = 1'b0;
    i_raddr_iid      = '0;
    i_raddr_addr     = '0;
    i_raddr_size     = '0;
    i_raddr_len      = '0;
    i_wresp_released = '0;
    i_rdata_released = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    check_val("o_wresp_release_en", 0, o_wresp_release_en);
    check_val("o_rdata_release_en", 0, o_rdata_release_en);
    check_val("o_waddr_ready", 1, o_waddr_ready);
    check_val("o_raddr_ready", 1, o_raddr_ready);
    check_val("o_wdata_ready", 0, o_wdata_ready);

    // Closed rank first, then a different row for the precharge
    first_row = row_w'($urandom);
    timed_read(3'd1, first_row, `ACT_COST);
    timed_read(3'd2, first_row ^ row_w'($urandom_range(63, 1)), `PRE_COST + `ACT_COST);
    write_with_data(3'd3);
    back_pressure_test();
    write_priority_test();
    repeat (2) @(negedge clk_i);

    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- delay_calc_top.f
+incdir+include
hw/delay_calc_pkg.sv
hw/write_slot_table.sv
hw/read_slot_table.sv
hw/rank_scheduler.sv
hw/release_register.sv
hw/delay_calc_top.sv
testbench/delay_calc_tb.sv

//--- Makefile
TOOL       ?= verilator
TOP        ?= delay_calc_tb
RTL_TOP    ?= delay_calc_top
FILELIST   ?= delay_calc_top.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
